// File: rtl/routerPkg.sv
package routerPkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int NUM_PORTS = 5;
  localparam int ID_W      = 3;   // Flit kind field
  localparam int LEN_W     = 12;  // Packet length budget
  localparam int FLIT_W    = 16;

  // Input ports, listed in rotation order
  typedef enum logic [ID_W-1:0] {
    PORT_LOCAL = 3'd0,
    PORT_NORTH = 3'd1,
    PORT_EAST  = 3'd2,
    PORT_WEST  = 3'd3,
    PORT_SOUTH = 3'd4
  } portId;

  // One bit per input port
  typedef logic [NUM_PORTS-1:0] portMask;

  typedef enum logic [ID_W-1:0] {
    KIND_IDLE = 3'd0,
    KIND_HEAD = 3'd1,
    KIND_BODY = 3'd2,
    KIND_TAIL = 3'd3
  } flitKind;

  //////////////////////////////
  // Flit word views
  //////////////////////////////

  // Head flit carries the hold budget for the arbiter
  typedef struct packed {
    flitKind          kind;
    logic [LEN_W-1:0] length;
    logic             spare;
  } headerView;

  typedef struct packed {
    flitKind                 kind;
    logic [FLIT_W-ID_W-1:0] payload;
  } bodyView;

  // Kind sits in the top bits of both views
  typedef union packed {
    headerView header;
    bodyView   body;
  } flitWord;

endpackage

// File: rtl/packetTimer.sv
`timescale 1ns/10ps

module packetTimer
  import routerPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  flitKind          flitKindIn,
  input  logic [LEN_W-1:0] lengthIn,
  input  logic             headValid,
  input  logic             running,
  output logic             timesUp
);

  logic [LEN_W-1:0] budget;  // Length of the latest head flit
  logic [LEN_W-1:0] count;   // Cycles held beyond the first

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      budget <= '0;
      count  <= '0;
    end
    else
    begin
      if (headValid && flitKindIn == KIND_HEAD)
        budget <= lengthIn;

      // Count only while the port keeps its grant
      if (running)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == budget);

endmodule

// File: rtl/switchArbiter.sv
`timescale 1ns/10ps

module switchArbiter
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord inFlit [NUM_PORTS],
  input  portMask inReq,
  output portMask grant
);

  portMask timesUp;
  portMask holdReq;   // Granted port may keep the switch
  portMask nextGrant;

  // First requester at or after startIdx, wrapping in rotation order
  function automatic portMask pickFrom(portMask req, int startIdx);
    portMask pick;
    int      idx;
    pick = '0;
    for (int k = 0; k < NUM_PORTS; k++)
    begin
      idx = startIdx + k;
      if (idx >= NUM_PORTS)
        idx = idx - NUM_PORTS;
      if (req[idx] && pick == '0)
        pick[idx] = 1'b1;
    end
    return pick;
  endfunction

  // Index of the set bit in a one-hot grant
  function automatic int holderOf(portMask g);
    int idx;
    idx = 0;
    for (int k = 0; k < NUM_PORTS; k++)
      if (g[k])
        idx = k;
    return idx;
  endfunction

  //////////////////////////////
  // Per-port hold timers
  //////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++)
  begin : g_timer
    assign holdReq[p] = grant[p] & inReq[p] & ~timesUp[p];

    packetTimer i_packetTimer (
      .clk        (clk),
      .rst        (rst),
      .flitKindIn (inFlit[p].header.kind),
      .lengthIn   (inFlit[p].header.length),
      .headValid  (inReq[p]),
      .running    (holdReq[p]),
      .timesUp    (timesUp[p])
    );
  end

  //////////////////////////////
  // Grant state
  //////////////////////////////

  always_comb
  begin
    if (grant == '0)
      nextGrant = pickFrom(inReq, int'(PORT_LOCAL));  // Fixed priority from idle
    else if (holdReq != '0)
      nextGrant = grant;
    else
    begin
      // Holder gives up, so search starts right after it and skips it
      nextGrant = pickFrom(inReq & ~grant, holderOf(grant) + 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= '0;
    else
      grant <= nextGrant;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant has more than one bit set: %b", grant);

  // Grant is never handed to a port that was not asking for it
  grantHadRequest: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) |-> ((grant & $past(inReq)) != '0))
    else $error("grant %b given without a request", grant);

endmodule

// File: rtl/flitStage.sv
`timescale 1ns/10ps

module flitStage
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord inFlit [NUM_PORTS],
  input  portMask inReq,
  output flitWord stageFlit [NUM_PORTS],
  output portMask stageValid,
  output portMask dropped
);

  portMask inPacket;
  portMask headIn;
  portMask bodyIn;
  portMask tailIn;

  // Only requested flits count; idle and unknown kinds are neither kept nor dropped
  always_comb
  begin
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      headIn[p] = inReq[p] && (inFlit[p].body.kind == KIND_HEAD);
      bodyIn[p] = inReq[p] && (inFlit[p].body.kind == KIND_BODY);
      tailIn[p] = inReq[p] && (inFlit[p].body.kind == KIND_TAIL);
    end
  end

  //////////////////////////////
  // Packet framing
  //////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inPacket   <= '0;
      stageValid <= '0;
      dropped    <= '0;
    end
    else
    begin
      inPacket   <= headIn | (inPacket & ~tailIn);  // Head also restarts a packet
      stageValid <= headIn | ((bodyIn | tailIn) & inPacket);
      dropped    <= (bodyIn | tailIn) & ~inPacket;
    end
  end

  always_ff @(posedge clk)
  begin
    stageFlit <= inFlit;
  end

  noDropWhenValid: assert property (@(posedge clk) disable iff (rst)
    (dropped & stageValid) == '0)
    else $error("port both dropped and valid: %b", dropped & stageValid);

endmodule

// File: rtl/outputMux.sv
`timescale 1ns/10ps

module outputMux
  import routerPkg::*;
(
  input  portMask grant,
  input  flitWord stageFlit [NUM_PORTS],
  input  portMask stageValid,
  output logic    outValid,
  output flitWord outFlit,
  output portId   outPort
);

  // Grant is one-hot or zero, so at most one port is picked
  always_comb
  begin
    outValid = 1'b0;
    outFlit  = '0;
    outPort  = PORT_LOCAL;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      if (grant[p])
      begin
        outValid = stageValid[p];  // Dropped flits stay invalid
        outFlit  = stageFlit[p];
        outPort  = portId'(p);
      end
    end
  end

endmodule

// File: rtl/outputPortAlloc.sv
`timescale 1ns/10ps

module outputPortAlloc
  import routerPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  flitWord inFlit [NUM_PORTS],
  input  portMask inReq,
  output portMask grant,
  output logic    outValid,
  output flitWord outFlit,
  output portId   outPort,
  output portMask dropped
);

  flitWord stageFlit [NUM_PORTS];
  portMask stageValid;

  //////////////////////////////
  // Arbiter and input stage run side by side
  //////////////////////////////

  switchArbiter i_switchArbiter (
    .clk    (clk),
    .rst    (rst),
    .inFlit (inFlit),
    .inReq  (inReq),
    .grant  (grant)
  );

  flitStage i_flitStage (
    .clk        (clk),
    .rst        (rst),
    .inFlit     (inFlit),
    .inReq      (inReq),
    .stageFlit  (stageFlit),
    .stageValid (stageValid),
    .dropped    (dropped)
  );

  // Registered grant lines up with the registered flits
  outputMux i_outputMux (
    .grant      (grant),
    .stageFlit  (stageFlit),
    .stageValid (stageValid),
    .outValid   (outValid),
    .outFlit    (outFlit),
    .outPort    (outPort)
  );

endmodule

// File: tests/clockGen.sv
`timescale 1ns/10ps

module clockGen
(
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD  = 20;  // 40 ns period
  localparam int RESET_CYCLES = 2;

  initial
  begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst = 1'b0;  // Release just after the edge
  end

endmodule

// File: tests/outputPortAllocTb.sv
`timescale 1ns/10ps

module outputPortAllocTb
  import routerPkg::*;
();

  logic    clk;
  logic    rst;
  flitWord inFlit [NUM_PORTS];
  portMask inReq;
  portMask grant;
  logic    outValid;
  flitWord outFlit;
  portId   outPort;
  portMask dropped;

  int          errors;
  string       testName;
  logic [31:0] rngState;

  // Reference model state
  portMask          mGrant;
  portMask          mValid;
  portMask          mDropped;
  portMask          mInPkt;
  flitWord          mFlit [NUM_PORTS];
  logic [LEN_W-1:0] mBudget [NUM_PORTS];
  logic [LEN_W-1:0] mHeld [NUM_PORTS];   // Cycles held beyond the first

  clockGen i_clockGen (.clk(clk), .rst(rst));

  outputPortAlloc i_outputPortAlloc (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inReq    (inReq),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit),
    .outPort  (outPort),
    .dropped  (dropped)
  );

  function automatic portMask maskOf(int p);
    return portMask'(1) << p;
  endfunction

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic checkMask(string what, portMask exp, portMask act);
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s %s: expected %b, actual %b", testName, what, exp, act);
    end
  endtask

  task automatic checkFlit(string what, flitWord exp, flitWord act);
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", testName, what, exp, act);
    end
  endtask

  task automatic checkPort(string what, portId exp, portId act);
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s %s: expected %0d, actual %0d", testName, what, exp, act);
    end
  endtask

  task automatic checkBit(string what, logic exp, logic act);
    if (act !== exp)
    begin
      errors++;
      $display("Fail %s %s: expected %b, actual %b", testName, what, exp, act);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  task automatic modelEdge();
    int      holder;
    portMask nxt;
    flitKind kind;
    logic    head;
    logic    late;  // Body or tail
    holder = -1;
    nxt    = '0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      mFlit[p] = inFlit[p];
      if (mGrant[p])
        holder = p;
    end
    if (rst)
    begin
      {mGrant, mValid, mDropped, mInPkt} = '0;
      for (int p = 0; p < NUM_PORTS; p++)
        {mBudget[p], mHeld[p]} = '0;
      return;
    end
    // Descending loops so the closest requester is assigned last
    if (holder < 0)
    begin
      for (int p = NUM_PORTS - 1; p >= 0; p--)
        if (inReq[p])
          nxt = maskOf(p);
    end
    else if (inReq[holder] && mHeld[holder] != mBudget[holder])
      nxt = mGrant;
    else
    begin
      for (int k = NUM_PORTS - 1; k >= 1; k--)
        if (inReq[(holder + k) % NUM_PORTS])
          nxt = maskOf((holder + k) % NUM_PORTS);
    end
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      kind        = inFlit[p].body.kind;
      head        = inReq[p] && kind == KIND_HEAD;
      late        = inReq[p] && (kind == KIND_BODY || kind == KIND_TAIL);
      mHeld[p]    = (nxt[p] && p == holder) ? mHeld[p] + 1'b1 : '0;
      if (head)
        mBudget[p] = inFlit[p].header.length;
      mValid[p]   = head || (late && mInPkt[p]);
      mDropped[p] = late && !mInPkt[p];
      mInPkt[p]   = head || (mInPkt[p] && !(late && kind == KIND_TAIL));
    end
    mGrant = nxt;
  endtask

  // One clock edge, then every output against the model
  task automatic stepCycle();
    flitWord expFlit;
    logic    expValid;
    portId   expPort;
    @(posedge clk);
    modelEdge();
    #2;
    expFlit  = '0;
    expValid = 1'b0;
    expPort  = PORT_LOCAL;
    for (int p = 0; p < NUM_PORTS; p++)
      if (mGrant[p])
      begin
        expFlit  = mFlit[p];
        expValid = mValid[p];
        expPort  = portId'(p);
      end
    checkMask("grant", mGrant, grant);
    checkMask("dropped", mDropped, dropped);
    checkBit("outValid", expValid, outValid);
    checkFlit("outFlit", expFlit, outFlit);
    checkPort("outPort", expPort, outPort);
  endtask

  task automatic waitGrant(portMask want, int limit);
    int n;
    n = 0;
    while (grant !== want && n < limit)
    begin
      stepCycle();
      n++;
    end
    if (grant !== want)
    begin
      errors++;
      $display("Timeout in %s: grant never reached %b", testName, want);
    end
  endtask

  task automatic drive(portId p, flitKind k, int len);
    inReq[p]                = 1'b1;
    inFlit[p].header.kind   = k;
    inFlit[p].header.length = LEN_W'(len);
    inFlit[p].header.spare  = 1'b0;
  endtask

  task automatic quiet();
    inReq = '0;
    for (int p = 0; p < NUM_PORTS; p++)
      inFlit[p] = '0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic resetTest();
    int n;
    testName = "resetTest";
    n        = 0;
    while (rst && n < 10)
    begin
      stepCycle();
      n++;
    end
    if (rst)
    begin
      errors++;
      $display("Timeout in %s: reset was never released", testName);
    end
    repeat (4)
    begin
      stepCycle();
      checkMask("idle grant", '0, grant);
      checkMask("idle dropped", '0, dropped);
      checkBit("idle outValid", 1'b0, outValid);
    end
  endtask

  task automatic priorityTest();
    flitWord northHead;
    testName = "priorityTest";
    drive(PORT_NORTH, KIND_HEAD, 2);
    drive(PORT_WEST, KIND_HEAD, 1);
    drive(PORT_SOUTH, KIND_HEAD, 1);
    northHead = inFlit[PORT_NORTH];
    stepCycle();
    checkMask("first grant", maskOf(PORT_NORTH), grant);
    checkPort("first port", PORT_NORTH, outPort);
    checkFlit("first flit", northHead, outFlit);
    quiet();
    waitGrant('0, 10);
  endtask

  task automatic budgetTest();
    testName = "budgetTest";
    drive(PORT_NORTH, KIND_HEAD, 3);
    drive(PORT_EAST, KIND_HEAD, 0);
    for (int i = 0; i < 4; i++)
    begin
      stepCycle();
      checkMask("North hold", maskOf(PORT_NORTH), grant);
      drive(PORT_NORTH, KIND_BODY, i);
    end
    stepCycle();
    checkMask("handover", maskOf(PORT_EAST), grant);
    drive(PORT_NORTH, KIND_HEAD, 0);  // Zero budget gives one cycle
    stepCycle();
    checkMask("short grant", maskOf(PORT_NORTH), grant);
    stepCycle();
    checkMask("short release", maskOf(PORT_EAST), grant);
    quiet();
    waitGrant('0, 10);
  endtask

  task automatic rotationTest();
    testName = "rotationTest";
    for (int p = 0; p < NUM_PORTS; p++)
      drive(portId'(p), KIND_HEAD, 0);
    waitGrant(maskOf(PORT_WEST), 10);
    stepCycle();
    checkMask("after West", maskOf(PORT_SOUTH), grant);
    stepCycle();
    checkMask("after South", maskOf(PORT_LOCAL), grant);
    stepCycle();
    checkMask("after Local", maskOf(PORT_NORTH), grant);
    quiet();
    waitGrant('0, 10);
    drive(PORT_EAST, KIND_HEAD, 0);
    stepCycle();
    checkMask("lone grant", maskOf(PORT_EAST), grant);
    stepCycle();
    checkMask("idle gap", '0, grant);
    stepCycle();
    checkMask("regrant", maskOf(PORT_EAST), grant);
    quiet();
    waitGrant('0, 10);
  endtask

  task automatic framingTest();
    testName = "framingTest";
    drive(PORT_LOCAL, KIND_HEAD, 7);  // Close any open packet first
    stepCycle();
    drive(PORT_LOCAL, KIND_TAIL, 0);
    stepCycle();
    quiet();
    waitGrant('0, 10);
    drive(PORT_LOCAL, KIND_BODY, 5);
    stepCycle();
    checkMask("stray body grant", maskOf(PORT_LOCAL), grant);
    checkMask("stray body", maskOf(PORT_LOCAL), dropped);
    checkBit("stray body valid", 1'b0, outValid);
    drive(PORT_LOCAL, KIND_HEAD, 7);
    stepCycle();
    checkBit("head valid", 1'b1, outValid);
    drive(PORT_LOCAL, KIND_BODY, 9);
    stepCycle();
    checkBit("body valid", 1'b1, outValid);
    drive(PORT_LOCAL, KIND_TAIL, 1);
    stepCycle();
    checkBit("tail valid", 1'b1, outValid);
    drive(PORT_LOCAL, KIND_BODY, 2);
    stepCycle();
    checkMask("late body", maskOf(PORT_LOCAL), dropped);
    checkBit("late body valid", 1'b0, outValid);
    quiet();
    waitGrant('0, 10);
  endtask

  task automatic randomTest();
    logic [31:0] r;
    testName = "randomTest";
    for (int c = 0; c < 300; c++)
    begin
      for (int p = 0; p < NUM_PORTS; p++)
      begin
        rngState                = xorshift(rngState);
        r                       = rngState;
        inReq[p]                = r[0] | r[1];
        inFlit[p]               = flitWord'(r[23:8]);
        inFlit[p].header.kind   = flitKind'({1'b0, r[3:2]});
        inFlit[p].header.length = LEN_W'(r[5:4]);  // Short holds keep the grant moving
      end
      stepCycle();
    end
    quiet();
    waitGrant('0, 10);
  endtask

  initial
  begin
    errors   = 0;
    rngState = 32'hd9793b61;
    quiet();
    resetTest();
    priorityTest();
    budgetTest();
    rotationTest();
    framingTest();
    randomTest();
    $display("Errors: %0d", errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: vlog.f
rtl/routerPkg.sv
rtl/packetTimer.sv
rtl/switchArbiter.sv
rtl/flitStage.sv
rtl/outputMux.sv
rtl/outputPortAlloc.sv
tests/clockGen.sv
tests/outputPortAllocTb.sv

// File: Bender.yml
package:
  name: outputPortAlloc

sources:
  - files:
      - rtl/routerPkg.sv
      - rtl/packetTimer.sv
      - rtl/switchArbiter.sv
      - rtl/flitStage.sv
      - rtl/outputMux.sv
      - rtl/outputPortAlloc.sv
  - target: test
    files:
      - tests/clockGen.sv
      - tests/outputPortAllocTb.sv
